// ==== rtl/tcb_params.svh ====
// bus subsystem widths, response delay and memory depth
`ifndef TCB_PARAMS_SVH
`define TCB_PARAMS_SVH

// byte address width
`define TCB_ADR_W 16

// data width and bytes per word
`define TCB_DAT_W 32
`define TCB_BYT (`TCB_DAT_W/8)

// response delay in cycles, memory and tracker agree on this
`define TCB_DLY 1

// memory depth in words
// word addresses at or above this flag an error
`define TCB_MEM_WORDS 256

`endif

// ==== rtl/tcb_pkg.sv ====
// struct types for log-size requests, byte-enable requests and responses
`include "tcb_params.svh"

package tcb_pkg;

    ////////////////////////////////////////
    // manager side
    ////////////////////////////////////////

    // log-size request
    // payload sits in the low bytes of wdt
    typedef struct packed {
        logic                  wen;
        logic                  ndn;
        logic [`TCB_ADR_W-1:0] adr;
        logic [1:0]            siz;
        logic [`TCB_DAT_W-1:0] wdt;
    } tcb_req_t;

    // attributes kept until the response arrives
    typedef struct packed {
        logic                         ndn;
        logic [$clog2(`TCB_BYT)-1:0]  off;
        logic [1:0]                   siz;
    } tcb_attr_t;

    ////////////////////////////////////////
    // memory side
    ////////////////////////////////////////

    // byte-enable request
    // data already steered onto its byte lanes
    typedef struct packed {
        logic                  wen;
        logic [`TCB_ADR_W-1:0] adr;
        logic [`TCB_BYT-1:0]   byt;
        logic [`TCB_DAT_W-1:0] wdt;
    } tcb_mem_req_t;

    // response, shared by both sides
    typedef struct packed {
        logic [`TCB_DAT_W-1:0] rdt;
        logic                  err;
    } tcb_rsp_t;

endpackage : tcb_pkg

// ==== rtl/tcb_req_track.sv ====
// request tracker, delays endianness, offset and size to line up with the response
`timescale 1ns/1ps
`include "tcb_params.svh"

module tcb_req_track import tcb_pkg::*; #(
    parameter int dly = `TCB_DLY
) (
    input  logic      clk,
    input  logic      reset,
    input  logic      req_vld,
    input  tcb_req_t  req,
    output logic      rsp_attr_vld,
    output tcb_attr_t rsp_attr
);

    localparam int off_w = $clog2(`TCB_BYT);

    // attributes of the current request
    tcb_attr_t req_attr;

    // shift line, stage 0 is the newest
    logic [dly-1:0] vld_sr;
    tcb_attr_t      attr_sr [dly];

    assign req_attr = '{ndn: req.ndn, off: req.adr[off_w-1:0], siz: req.siz};

    ////////////////////////////////////////
    // shift line
    ////////////////////////////////////////

    // valid bits, cleared on reset
    always_ff @(posedge clk) begin
        if (reset) begin
            vld_sr <= '0;
        end else begin
            vld_sr[0] <= req_vld;
            for (int i = 1; i < dly; i++) begin
                vld_sr[i] <= vld_sr[i-1];
            end
        end
    end

    // attributes, only loaded on an accepted request
    always_ff @(posedge clk) begin
        if (req_vld) begin
            attr_sr[0] <= req_attr;
        end
        for (int i = 1; i < dly; i++) begin
            attr_sr[i] <= attr_sr[i-1];
        end
    end

    // oldest stage meets the response
    assign rsp_attr_vld = vld_sr[dly-1];
    assign rsp_attr     = attr_sr[dly-1];

    ////////////////////////////////////////
    // checks
    ////////////////////////////////////////

    // every request shows up exactly dly cycles later
    assert property (@(posedge clk) disable iff (reset)
        req_vld |-> ##dly rsp_attr_vld)
        else $error("tracker lost a request");

    // and nothing shows up that was not requested
    assert property (@(posedge clk) disable iff (reset)
        rsp_attr_vld |-> $past(req_vld, dly))
        else $error("tracker produced a spurious entry");

endmodule : tcb_req_track

// ==== rtl/tcb_logsize2byteena.sv ====
// log-size to byte-enable converter with write and read lane steering
`timescale 1ns/1ps
`include "tcb_params.svh"

module tcb_logsize2byteena import tcb_pkg::*; #(
    parameter bit aligned = 1'b0
) (
    input  logic         req_vld,
    input  tcb_req_t     req,
    input  tcb_attr_t    rsp_attr,
    input  tcb_rsp_t     mem_rsp,
    output logic         mem_vld,
    output tcb_mem_req_t mem_req,
    output tcb_rsp_t     rsp
);

    localparam int nbyt  = `TCB_BYT;
    localparam int off_w = $clog2(nbyt);

    // request and response side offsets
    logic [off_w-1:0] req_off;
    logic [off_w-1:0] rsp_off;

    // byte enables and lane views of the data
    logic [nbyt-1:0]      mem_byt;
    logic [nbyt-1:0][7:0] req_wdt;
    logic [nbyt-1:0][7:0] mem_wdt;
    logic [nbyt-1:0][7:0] mem_rdt;
    logic [nbyt-1:0][7:0] rsp_rdt;

    // or of each bit with all bits above it
    function automatic logic [nbyt-1:0] prefix_or(input logic [nbyt-1:0] val);
        logic [nbyt-1:0] res;
        res[nbyt-1] = val[nbyt-1];
        for (int i = nbyt - 1; i > 0; i--) begin
            res[i-1] = res[i] | val[i-1];
        end
        return res;
    endfunction

    assign req_off = req.adr[off_w-1:0];
    assign rsp_off = rsp_attr.off;
    assign req_wdt = req.wdt;
    assign mem_rdt = mem_rsp.rdt;

    ////////////////////////////////////////
    // lane steering
    ////////////////////////////////////////

    if (aligned) begin : gen_aligned

        // offset bits kept for each size
        logic [off_w-1:0] req_msk;
        logic [off_w-1:0] rsp_msk;

        always_comb begin
            for (int k = 0; k < off_w; k++) begin
                req_msk[k] = (k >= req.siz);
                rsp_msk[k] = (k >= rsp_attr.siz);
            end
        end

        // enable the lanes of the naturally aligned slot
        // payload replicated across all lanes
        always_comb begin
            for (int i = 0; i < nbyt; i++) begin
                mem_byt[i] = ((req_off & req_msk) == (off_w'(i) & req_msk));
                mem_wdt[i] = req_wdt[off_w'(i) & ~req_msk];
            end
        end

        // pull the slot down to the low bytes
        // upper result bytes repeat the word, don't care
        always_comb begin
            logic [nbyt-1:0] src;
            for (int i = 0; i < nbyt; i++) begin
                src = (~prefix_or(nbyt'(i)) & nbyt'(rsp_off & rsp_msk)) | nbyt'(i);
                rsp_rdt[i] = mem_rdt[off_w'(src)];
            end
        end

    end else begin : gen_unaligned

        // byte counts, 2 to the power siz
        logic [off_w:0] req_cnt;
        logic [off_w:0] rsp_cnt;

        assign req_cnt = (off_w + 1)'(1) << req.siz;
        assign rsp_cnt = (off_w + 1)'(1) << rsp_attr.siz;

        // enables and write data rotated by the offset, wrapping in the word
        always_comb begin
            logic [off_w-1:0] rel;
            logic [off_w-1:0] src;
            for (int i = 0; i < nbyt; i++) begin
                rel = off_w'(i) - req_off;
                mem_byt[i] = ({1'b0, rel} < req_cnt);
                if (req.ndn) begin
                    // big endian, payload bytes reversed within the count
                    src = off_w'(req_cnt - 1'b1) - off_w'(i) + req_off;
                end else begin
                    src = rel;
                end
                mem_wdt[i] = req_wdt[src];
            end
        end

        // read data, mirror of the write mapping
        always_comb begin
            logic [off_w-1:0] src;
            for (int i = 0; i < nbyt; i++) begin
                if (rsp_attr.ndn) begin
                    src = off_w'(rsp_cnt - 1'b1) - off_w'(i) + rsp_off;
                end else begin
                    src = off_w'(i) + rsp_off;
                end
                rsp_rdt[i] = mem_rdt[src];
            end
        end

    end

    ////////////////////////////////////////
    // outputs
    ////////////////////////////////////////

    // request side, every valid cycle is passed on
    assign mem_vld = req_vld;
    assign mem_req = '{wen: req.wen, adr: req.adr, byt: mem_byt, wdt: mem_wdt};

    // response side, error passes straight through
    assign rsp = '{rdt: rsp_rdt, err: mem_rsp.err};

endmodule : tcb_logsize2byteena

// ==== rtl/tcb_mem.sv ====
// byte-enable word memory, one-cycle registered response with range error
`timescale 1ns/1ps
`include "tcb_params.svh"

module tcb_mem import tcb_pkg::*; (
    input  logic         clk,
    input  logic         reset,
    input  logic         mem_vld,
    input  tcb_mem_req_t mem_req,
    output logic         mem_rsp_vld,
    output tcb_rsp_t     mem_rsp
);

    localparam int nbyt   = `TCB_BYT;
    localparam int off_w  = $clog2(nbyt);
    localparam int word_w = `TCB_ADR_W - off_w;
    localparam int idx_w  = $clog2(`TCB_MEM_WORDS);

    // storage, one byte per lane
    logic [nbyt-1:0][7:0] mem [`TCB_MEM_WORDS];

    // word address and its decode
    logic [word_w-1:0] word_adr;
    logic [idx_w-1:0]  idx;
    logic              in_range;
    logic              wr_en;

    assign word_adr = mem_req.adr[`TCB_ADR_W-1:off_w];
    assign idx      = word_adr[idx_w-1:0];
    assign in_range = (int'(word_adr) < `TCB_MEM_WORDS);

    // out of range writes are dropped
    assign wr_en = mem_vld & mem_req.wen & in_range;

    ////////////////////////////////////////
    // write port
    ////////////////////////////////////////

    // only enabled lanes change
    always_ff @(posedge clk) begin
        if (wr_en) begin
            for (int i = 0; i < nbyt; i++) begin
                if (mem_req.byt[i]) begin
                    mem[idx][i] <= mem_req.wdt[8*i +: 8];
                end
            end
        end
    end

    ////////////////////////////////////////
    // response
    ////////////////////////////////////////

    // response valid one cycle after the request
    always_ff @(posedge clk) begin
        if (reset) begin
            mem_rsp_vld <= 1'b0;
        end else begin
            mem_rsp_vld <= mem_vld;
        end
    end

    // read data and error
    // writes and out of range accesses return zero data
    always_ff @(posedge clk) begin
        if (mem_vld) begin
            mem_rsp.err <= ~in_range;
            if (in_range && !mem_req.wen) begin
                mem_rsp.rdt <= mem[idx];
            end else begin
                mem_rsp.rdt <= '0;
            end
        end
    end

    // converter must never send an empty write
    assert property (@(posedge clk) disable iff (reset)
        (mem_vld && mem_req.wen) |-> (mem_req.byt != '0))
        else $error("write request with no byte enables");

endmodule : tcb_mem

// ==== rtl/tcb_sub_top.sv ====
// bus subsystem top, tracker and converter in front of the word memory
`timescale 1ns/1ps
`include "tcb_params.svh"

module tcb_sub_top import tcb_pkg::*; #(
    parameter bit aligned = 1'b0
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     req_vld,
    input  tcb_req_t req,
    output logic     rsp_vld,
    output tcb_rsp_t rsp
);

    // tracked attributes
    logic         rsp_attr_vld;
    tcb_attr_t    rsp_attr;

    // memory side bus
    logic         mem_vld;
    tcb_mem_req_t mem_req;
    logic         mem_rsp_vld;
    tcb_rsp_t     mem_rsp;

    ////////////////////////////////////////
    // pipeline
    ////////////////////////////////////////

    tcb_req_track #(.dly(`TCB_DLY)) u_track (
        .clk          (clk),
        .reset        (reset),
        .req_vld      (req_vld),
        .req          (req),
        .rsp_attr_vld (rsp_attr_vld),
        .rsp_attr     (rsp_attr)
    );

    tcb_logsize2byteena #(.aligned(aligned)) u_conv (
        .req_vld  (req_vld),
        .req      (req),
        .rsp_attr (rsp_attr),
        .mem_rsp  (mem_rsp),
        .mem_vld  (mem_vld),
        .mem_req  (mem_req),
        .rsp      (rsp)
    );

    tcb_mem u_mem (
        .clk         (clk),
        .reset       (reset),
        .mem_vld     (mem_vld),
        .mem_req     (mem_req),
        .mem_rsp_vld (mem_rsp_vld),
        .mem_rsp     (mem_rsp)
    );

    // response valid comes from the memory
    assign rsp_vld = mem_rsp_vld;

    // tracker and memory delays must agree
    assert property (@(posedge clk) disable iff (reset)
        rsp_attr_vld == mem_rsp_vld)
        else $error("tracked attributes out of step with memory response");

endmodule : tcb_sub_top

// ==== tb/tcb_tb.sv ====
// testbench for the bus subsystem with a shadow memory model and assertions
`timescale 1ns/1ps
`include "tcb_params.svh"

module tcb_tb import tcb_pkg::*; ();

    localparam int n_rand = 200;
    localparam int n_err  = 16;
    // fill, merge, big endian, random, error and sweep phases
    localparam int n_req  = `TCB_MEM_WORDS + 24 + 24 + n_rand + n_err + `TCB_MEM_WORDS;

    // expected response and the bytes that count
    typedef struct packed {
        tcb_rsp_t              rsp;
        logic [`TCB_DAT_W-1:0] msk;
    } exp_t;

    logic     clk;
    logic     reset;
    logic     req_vld;
    tcb_req_t req;
    logic     rsp_vld;
    tcb_rsp_t rsp;

    // model state
    logic [3:0][7:0] shadow [`TCB_MEM_WORDS];
    exp_t            exp_q [$];
    exp_t            exp_cur;
    logic            exp_vld;
    logic [31:0]     lfsr;

    tcb_sub_top UUT (
        .clk     (clk),
        .reset   (reset),
        .req_vld (req_vld),
        .req     (req),
        .rsp_vld (rsp_vld),
        .rsp     (rsp)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    ////////////////////////////////////////
    // failure reporting
    ////////////////////////////////////////

    task automatic stop_run();
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string sig, input logic [31:0] got,
                                   input logic [31:0] want);
        $display("mismatch at %0t: %s got %h expected %h", $time, sig, got, want);
        stop_run();
    endtask

    task automatic report_failure(input string what);
        $display("error at %0t: %s", $time, what);
        stop_run();
    endtask

    ////////////////////////////////////////
    // random source and model
    ////////////////////////////////////////

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // one step per bit taken
    task automatic take_bits(input int n, output logic [31:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            val  = {val[30:0], lfsr[0]};
        end
    endtask

    // pattern over the whole word address
    function automatic logic [31:0] fill_word(input int word);
        return {~8'(word), 8'(word) ^ 8'h3c, 8'(word) + 8'h11, 8'(word)};
    endfunction

    // apply one request to the shadow and queue its response
    task automatic apply_model(input tcb_req_t r);
        exp_t            e;
        logic [3:0][7:0] pay;
        int              word;
        int              off;
        int              cnt;
        int              rel;
        int              lane;
        word = int'(r.adr[`TCB_ADR_W-1:2]);
        off  = int'(r.adr[1:0]);
        cnt  = 1 << r.siz;
        pay  = r.wdt;
        e    = '0;
        if (word >= `TCB_MEM_WORDS) begin
            // out of range gives zero data and leaves the memory untouched
            e.rsp.err = 1'b1;
            e.msk     = '1;
        end else if (r.wen) begin
            for (int i = 0; i < 4; i++) begin
                rel = (i - off + 4) % 4;
                if (rel < cnt) begin
                    shadow[word][i] = r.ndn ? pay[cnt - 1 - rel] : pay[rel];
                end
            end
        end else begin
            // result byte j read from its lane with wrap in the word
            for (int j = 0; j < cnt; j++) begin
                lane = r.ndn ? (off + cnt - 1 - j) % 4 : (off + j) % 4;
                e.rsp.rdt[8*j +: 8] = shadow[word][lane];
                e.msk[8*j +: 8]     = 8'hff;
            end
        end
        exp_q.push_back(e);
    endtask

    ////////////////////////////////////////
    // drive and check
    ////////////////////////////////////////

    task automatic issue(input logic wen, input logic ndn, input logic [15:0] adr,
                         input logic [1:0] siz, input logic [31:0] wdt);
        tcb_req_t r;
        r = '{wen: wen, ndn: ndn, adr: adr, siz: siz, wdt: wdt};
        @(posedge clk);
        req_vld <= 1'b1;
        req     <= r;
        apply_model(r);
    endtask

    task automatic idle_cycle();
        @(posedge clk);
        req_vld <= 1'b0;
    endtask

    // expected response lines up one cycle after the request
    always @(posedge clk) begin
        if (reset) begin
            exp_vld <= 1'b0;
        end else begin
            exp_vld <= req_vld;
            if (req_vld) begin
                exp_cur <= exp_q.pop_front();
            end
        end
    end

    assert property (@(posedge clk) disable iff (reset) rsp_vld == exp_vld)
        else report_mismatch("rsp_vld", 32'($sampled(rsp_vld)), 32'($sampled(exp_vld)));

    assert property (@(posedge clk) disable iff (reset)
        exp_vld |-> rsp.err == exp_cur.rsp.err)
        else report_mismatch("rsp.err", 32'($sampled(rsp.err)),
                             32'($sampled(exp_cur.rsp.err)));

    // bytes above the count are don't care
    assert property (@(posedge clk) disable iff (reset)
        exp_vld |-> (rsp.rdt & exp_cur.msk) == (exp_cur.rsp.rdt & exp_cur.msk))
        else report_mismatch("rsp.rdt", $sampled(rsp.rdt) & $sampled(exp_cur.msk),
                             $sampled(exp_cur.rsp.rdt) & $sampled(exp_cur.msk));

    // watchdog
    initial begin
        repeat ((n_req * 4) + 50) @(posedge clk);
        report_failure("timeout, the tests did not finish in time");
    end

    initial begin : stim
        logic [31:0] v;
        logic [31:0] d;
        logic [31:0] f;
        logic [1:0]  s;
        req_vld = 1'b0;
        req     = '0;
        reset   = 1'b1;
        lfsr    = 32'h53db;
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        // quiet bus after reset
        repeat (4) idle_cycle();

        // fill every word back to back
        for (int w = 0; w < `TCB_MEM_WORDS; w++) begin
            issue(1'b1, 1'b0, 16'(w << 2), 2'd2, fill_word(w));
        end

        // little endian merges at every size and offset followed by a word read
        for (int sz = 0; sz < 3; sz++) begin
            for (int o = 0; o < 4; o++) begin
                take_bits(32, d);
                issue(1'b1, 1'b0, 16'((5 << 2) | o), 2'(sz), d);
                issue(1'b0, 1'b0, 16'(5 << 2), 2'd2, '0);
            end
        end

        // big endian round trip and the swapped lanes read little endian
        for (int sz = 1; sz < 3; sz++) begin
            for (int o = 0; o < 4; o++) begin
                take_bits(32, d);
                issue(1'b1, 1'b1, 16'((9 << 2) | o), 2'(sz), d);
                issue(1'b0, 1'b1, 16'((9 << 2) | o), 2'(sz), '0);
                issue(1'b0, 1'b0, 16'(9 << 2), 2'd2, '0);
            end
        end

        // random transfers with gaps
        // many of them cross the word boundary
        for (int n = 0; n < n_rand; n++) begin
            take_bits(10, v);
            take_bits(2, d);
            s = (d[1:0] == 2'd3) ? 2'd2 : d[1:0];
            take_bits(2, f);
            take_bits(32, d);
            issue(f[0], f[1], {6'd0, v[9:0]}, s, d);
            take_bits(1, d);
            if (d[0]) begin
                idle_cycle();
            end
        end

        // beyond the memory depth
        for (int n = 0; n < n_err; n++) begin
            take_bits(6, v);
            take_bits(10, d);
            issue(1'(n), 1'b0, {v[5:0] | 6'd1, d[9:0]}, 2'd2, 32'hdead_beef);
        end

        // every valid word must be intact
        for (int w = 0; w < `TCB_MEM_WORDS; w++) begin
            issue(1'b0, 1'b0, 16'(w << 2), 2'd2, '0);
        end

        idle_cycle();
        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
        repeat (3) @(posedge clk);
        $display("PASS: all tests");
        $finish;
    end

endmodule : tcb_tb

// ==== tcb_sub_top.f ====
+incdir+rtl
rtl/tcb_pkg.sv
rtl/tcb_req_track.sv
rtl/tcb_logsize2byteena.sv
rtl/tcb_mem.sv
rtl/tcb_sub_top.sv
tb/tcb_tb.sv

// ==== run.sh ====
#!/bin/sh
# build the testbench with Verilator, then run it
# the exit status of the simulation is the result

verilator --binary --assert -j 0 \
    -f tcb_sub_top.f \
    --top-module tcb_tb \
    --Mdir obj_dir -o tcb_sim \
    && ./obj_dir/tcb_sim \
    || exit 1
